/* hdl/gold_miner_settings.svh */
`ifndef GOLD_MINER_SETTINGS_SVH
`define GOLD_MINER_SETTINGS_SVH

////////////////////////////////////////
// Coordinates and field limits
////////////////////////////////////////
`define GM_X_W              11
`define GM_Y_W              10
`define GM_HOOK_SIZE        32
`define GM_FIELD_RIGHT      1259
`define GM_FIELD_LEFT       10
`define GM_FIELD_BOTTOM     779

// Home zone above the playfield, top edge of the hook
`define GM_HOME_Y_MAX       242
`define GM_HOME_X_MIN       560
`define GM_HOME_X_MAX       710

////////////////////////////////////////
// Objects and points
////////////////////////////////////////
`define GM_GOLD_SIZE        59
`define GM_DIAMOND_SIZE     39
`define GM_STONE_SIZE       79
`define GM_GOLD_POINTS      6
`define GM_DIAMOND_POINTS   10
`define GM_STONE_POINTS     0
`define GM_NUM_OBJECTS      10
`define GM_SCORE_W          8

// Round timing on the 60 Hz tick
`define GM_TICKS_PER_SECOND 60
`define GM_ROUND_SECONDS    90

////////////////////////////////////////
// Layout, top-left corners
////////////////////////////////////////
// Gold
`define GM_OBJ0_X 100
`define GM_OBJ0_Y 320
`define GM_OBJ1_X 400
`define GM_OBJ1_Y 450
`define GM_OBJ2_X 800
`define GM_OBJ2_Y 350
`define GM_OBJ3_X 1050
`define GM_OBJ3_Y 500
`define GM_OBJ4_X 250
`define GM_OBJ4_Y 620
// Diamonds
`define GM_OBJ5_X 600
`define GM_OBJ5_Y 400
`define GM_OBJ6_X 900
`define GM_OBJ6_Y 600
// Stones
`define GM_OBJ7_X 150
`define GM_OBJ7_Y 450
`define GM_OBJ8_X 700
`define GM_OBJ8_Y 550
`define GM_OBJ9_X 1100
`define GM_OBJ9_Y 330

`endif

/* hdl/gold_miner_pkg.sv */
`include "gold_miner_settings.svh"

package gold_miner_pkg;

    ////////////////////////////////////////
    // Positions
    ////////////////////////////////////////
    typedef logic [`GM_X_W-1:0] x_coord_t;
    typedef logic [`GM_Y_W-1:0] y_coord_t;

    // Top-left corner of the hook box
    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
    } hook_pos_t;

    ////////////////////////////////////////
    // Game enums
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        gold,
        diamond,
        stone
    } object_kind_t;

    typedef enum logic [1:0] {
        waving,
        stretching,
        hitting,
        missing
    } hook_state_t;

    // Detector output, valid every cycle
    typedef struct packed {
        logic         caught;
        logic [3:0]   index;
        object_kind_t kind;
        logic         out_of_field;
        logic         at_home;
        logic         spare;
    } catch_result_t;

endpackage

/* hdl/catch_detector.sv */
`timescale 1ns/1ns
`include "gold_miner_settings.svh"

module catch_detector
(
    input  logic                          pixclk_60,
    input  logic                          rst,
    input  gold_miner_pkg::hook_pos_t     hook_pos,
    input  logic [`GM_NUM_OBJECTS-1:0]    collected,
    output gold_miner_pkg::catch_result_t result
);

    // Built-in layout
    localparam int obj_x [`GM_NUM_OBJECTS] = '{
        `GM_OBJ0_X, `GM_OBJ1_X, `GM_OBJ2_X, `GM_OBJ3_X, `GM_OBJ4_X,
        `GM_OBJ5_X, `GM_OBJ6_X, `GM_OBJ7_X, `GM_OBJ8_X, `GM_OBJ9_X
    };
    localparam int obj_y [`GM_NUM_OBJECTS] = '{
        `GM_OBJ0_Y, `GM_OBJ1_Y, `GM_OBJ2_Y, `GM_OBJ3_Y, `GM_OBJ4_Y,
        `GM_OBJ5_Y, `GM_OBJ6_Y, `GM_OBJ7_Y, `GM_OBJ8_Y, `GM_OBJ9_Y
    };
    localparam gold_miner_pkg::object_kind_t obj_kind [`GM_NUM_OBJECTS] = '{
        gold_miner_pkg::gold, gold_miner_pkg::gold, gold_miner_pkg::gold,
        gold_miner_pkg::gold, gold_miner_pkg::gold,
        gold_miner_pkg::diamond, gold_miner_pkg::diamond,
        gold_miner_pkg::stone, gold_miner_pkg::stone, gold_miner_pkg::stone
    };

    function automatic int obj_size(input gold_miner_pkg::object_kind_t kind);
        case (kind)
            gold_miner_pkg::gold:    return `GM_GOLD_SIZE;
            gold_miner_pkg::diamond: return `GM_DIAMOND_SIZE;
            default:                 return `GM_STONE_SIZE;
        endcase
    endfunction

    // One spare bit so the hook edges never wrap
    logic [`GM_X_W:0] hook_left;
    logic [`GM_X_W:0] hook_right;
    logic [`GM_Y_W:0] hook_top;
    logic [`GM_Y_W:0] hook_bottom;
    logic [`GM_NUM_OBJECTS-1:0] hit;
    gold_miner_pkg::catch_result_t result_next;

    assign hook_left   = {1'b0, hook_pos.x};
    assign hook_right  = hook_left + `GM_HOOK_SIZE;
    assign hook_top    = {1'b0, hook_pos.y};
    assign hook_bottom = hook_top + `GM_HOOK_SIZE;

    ////////////////////////////////////////
    // Overlap tests, all objects in parallel
    ////////////////////////////////////////
    always_comb
    begin
        for (int i = 0; i < `GM_NUM_OBJECTS; i++)
        begin
            hit[i] = !collected[i]
                && (int'(hook_left) < obj_x[i] + obj_size(obj_kind[i]))
                && (int'(hook_right) > obj_x[i])
                && (int'(hook_top) < obj_y[i] + obj_size(obj_kind[i]))
                && (int'(hook_bottom) > obj_y[i]);
        end
    end

    always_comb
    begin
        result_next = '0;
        // Walk downwards so the lowest index is the last to land
        for (int i = `GM_NUM_OBJECTS - 1; i >= 0; i--)
        begin
            if (hit[i])
            begin
                result_next.caught = 1'b1;
                result_next.index  = 4'(i);
                result_next.kind   = obj_kind[i];
            end
        end
        result_next.out_of_field = (hook_right >= `GM_FIELD_RIGHT)
            || (hook_left <= `GM_FIELD_LEFT)
            || (hook_bottom >= `GM_FIELD_BOTTOM);
        result_next.at_home = (hook_top <= `GM_HOME_Y_MAX)
            && (hook_left >= `GM_HOME_X_MIN)
            && (hook_left <= `GM_HOME_X_MAX);
    end

    always_ff @(posedge pixclk_60)
    begin
        if (rst)
            result <= '0;
        else
            result <= result_next;
    end

endmodule

/* hdl/round_timer.sv */
`timescale 1ns/1ns
`include "gold_miner_settings.svh"

module round_timer
(
    input  logic       pixclk_60,
    input  logic       rst,
    output logic [6:0] time_left,
    output logic       game_over
);

    localparam int tick_w = $clog2(`GM_TICKS_PER_SECOND);

    logic [tick_w-1:0] tick_count;
    logic              second_done;

    // Last tick of the current second
    assign second_done = (tick_count == tick_w'(`GM_TICKS_PER_SECOND - 1));

    always_ff @(posedge pixclk_60)
    begin
        if (rst)
        begin
            tick_count <= '0;
            time_left  <= 7'(`GM_ROUND_SECONDS);
        end
        else
        begin
            if (second_done)
                tick_count <= '0;
            else
                tick_count <= tick_count + 1'b1;
            // Countdown holds at zero
            if (second_done && time_left != '0)
                time_left <= time_left - 1'b1;
        end
    end

    assign game_over = (time_left == '0);

endmodule

/* hdl/hook_controller.sv */
`timescale 1ns/1ns
`include "gold_miner_settings.svh"

module hook_controller
(
    input  logic                          pixclk_60,
    input  logic                          rst,
    input  logic                          button,
    input  gold_miner_pkg::catch_result_t result,
    input  logic                          game_over,
    output gold_miner_pkg::hook_state_t   state,
    output logic [`GM_SCORE_W-1:0]        score,
    output logic [`GM_NUM_OBJECTS-1:0]    collected
);

    gold_miner_pkg::hook_state_t state_next;
    logic                        take_catch;
    logic [`GM_SCORE_W-1:0]      points;

    ////////////////////////////////////////
    // Points per caught kind
    ////////////////////////////////////////
    always_comb
    begin
        case (result.kind)
            gold_miner_pkg::gold:    points = `GM_SCORE_W'(`GM_GOLD_POINTS);
            gold_miner_pkg::diamond: points = `GM_SCORE_W'(`GM_DIAMOND_POINTS);
            default:                 points = `GM_SCORE_W'(`GM_STONE_POINTS);
        endcase
    end

    // A catch only counts while the hook is still going out
    assign take_catch = !game_over
        && (state == gold_miner_pkg::stretching)
        && !result.out_of_field
        && result.caught;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    always_comb
    begin
        state_next = state;
        case (state)
            gold_miner_pkg::waving:
                if (button)
                    state_next = gold_miner_pkg::stretching;
            gold_miner_pkg::stretching:
                if (result.out_of_field)
                    state_next = gold_miner_pkg::missing;
                else if (result.caught)
                    state_next = gold_miner_pkg::hitting;
            gold_miner_pkg::hitting,
            gold_miner_pkg::missing:
                if (result.at_home)
                    state_next = gold_miner_pkg::waving;
            default:
                state_next = gold_miner_pkg::waving;
        endcase
        // Round over, hook parked for good
        if (game_over)
            state_next = gold_miner_pkg::waving;
    end

    always_ff @(posedge pixclk_60)
    begin
        if (rst)
            state <= gold_miner_pkg::waving;
        else
            state <= state_next;
    end

    ////////////////////////////////////////
    // Score and collected mask
    ////////////////////////////////////////
    always_ff @(posedge pixclk_60)
    begin
        if (rst)
        begin
            score     <= '0;
            collected <= '0;
        end
        else if (take_catch)
        begin
            score                   <= score + points;
            collected[result.index] <= 1'b1;
        end
    end

endmodule

/* hdl/gold_miner_core.sv */
`timescale 1ns/1ns
`include "gold_miner_settings.svh"

module gold_miner_core
(
    input  logic                        pixclk_60,
    input  logic                        rst,
    input  logic                        button,
    input  gold_miner_pkg::hook_pos_t   hook_pos,
    output gold_miner_pkg::hook_state_t state,
    output logic [`GM_SCORE_W-1:0]      score,
    output logic [6:0]                  time_left,
    output logic                        game_over
);

    gold_miner_pkg::catch_result_t   result;
    logic [`GM_NUM_OBJECTS-1:0]      collected;

    // Overlap and field tests, one cycle behind hook_pos
    catch_detector u_catch_detector (
        .pixclk_60 (pixclk_60),
        .rst       (rst),
        .hook_pos  (hook_pos),
        .collected (collected),
        .result    (result)
    );

    round_timer u_round_timer (
        .pixclk_60 (pixclk_60),
        .rst       (rst),
        .time_left (time_left),
        .game_over (game_over)
    );

    // Collected mask loops back into the detector
    hook_controller u_hook_controller (
        .pixclk_60 (pixclk_60),
        .rst       (rst),
        .button    (button),
        .result    (result),
        .game_over (game_over),
        .state     (state),
        .score     (score),
        .collected (collected)
    );

endmodule

/* verif/gold_miner_tb.sv */
`timescale 1ns/1ns
`include "gold_miner_settings.svh"

module gold_miner_tb;

    logic                        pixclk_60;
    logic                        rst;
    logic                        button;
    gold_miner_pkg::hook_pos_t   hook_pos;
    gold_miner_pkg::hook_state_t state;
    logic [`GM_SCORE_W-1:0]      score;
    logic [6:0]                  time_left;
    logic                        game_over;

    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          expected_score;
    logic [15:0] lfsr_state;

    gold_miner_core uut (
        .pixclk_60 (pixclk_60),
        .rst       (rst),
        .button    (button),
        .hook_pos  (hook_pos),
        .state     (state),
        .score     (score),
        .time_left (time_left),
        .game_over (game_over)
    );

    always #10 pixclk_60 = ~pixclk_60;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            $display("** Error %s: %s expected %0d, actual %0d", name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        @(posedge pixclk_60);
        rst <= 1'b1;
        repeat (3) @(posedge pixclk_60);
        rst <= 1'b0;
    endtask

    task automatic move_hook(input int x, input int y);
        @(posedge pixclk_60);
        hook_pos.x <= gold_miner_pkg::x_coord_t'(x);
        hook_pos.y <= gold_miner_pkg::y_coord_t'(y);
    endtask

    task automatic press_button();
        @(posedge pixclk_60);
        button <= 1'b1;
        @(posedge pixclk_60);
        button <= 1'b0;
    endtask

    task automatic wait_state(input gold_miner_pkg::hook_state_t target, input string name);
        int cycles;
        cycles = 0;
        @(negedge pixclk_60);
        while (state != target && cycles < 40)
        begin
            @(negedge pixclk_60);
            cycles++;
        end
        if (state != target)
        begin
            $display("%s: hook state %s never came within 40 cycles", name, target.name());
            error_count++;
        end
    endtask

    // State and score must hold for a number of cycles
    task automatic hold_state(input gold_miner_pkg::hook_state_t expected, input int cycles,
                              input string name);
        repeat (cycles)
        begin
            @(negedge pixclk_60);
            check_value(name, "state", int'(expected), int'(state));
            check_value(name, "score", expected_score, int'(score));
        end
    endtask

    // Fire from waving and steer the hook to a spot
    task automatic launch_hook(input int x, input int y, input string name);
        press_button();
        wait_state(gold_miner_pkg::stretching, name);
        move_hook(x, y);
    endtask

    task automatic fire_and_reach(input int x, input int y,
                                  input gold_miner_pkg::hook_state_t target, input string name);
        launch_hook(x, y, name);
        wait_state(target, name);
    endtask

    // Random spot inside the home zone
    task automatic park_home(input string name);
        int rx;
        int ry;
        take_bits(7, rx);
        take_bits(7, ry);
        move_hook(`GM_HOME_X_MIN + rx, 100 + ry);
        wait_state(gold_miner_pkg::waving, name);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
            $display("%s: ok", name);
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic reset_values();
        int errors_before;
        errors_before = error_count;
        @(negedge pixclk_60);
        check_value("reset_values", "state", int'(gold_miner_pkg::waving), int'(state));
        check_value("reset_values", "score", 0, int'(score));
        check_value("reset_values", "time_left", `GM_ROUND_SECONDS, int'(time_left));
        check_value("reset_values", "game_over", 0, int'(game_over));
        report_test("reset_values", errors_before);
    endtask

    task automatic gold_catch_and_return();
        int errors_before;
        errors_before = error_count;
        fire_and_reach(110, 330, gold_miner_pkg::hitting, "gold_catch");
        expected_score += `GM_GOLD_POINTS;
        check_value("gold_catch", "score", expected_score, int'(score));
        park_home("gold_catch");
        report_test("gold_catch", errors_before);
    endtask

    task automatic diamond_stone_and_recatch();
        int errors_before;
        errors_before = error_count;
        fire_and_reach(610, 410, gold_miner_pkg::hitting, "diamond_stone");
        expected_score += `GM_DIAMOND_POINTS;
        check_value("diamond_stone", "score", expected_score, int'(score));
        park_home("diamond_stone");
        fire_and_reach(160, 460, gold_miner_pkg::hitting, "diamond_stone");
        expected_score += `GM_STONE_POINTS;
        check_value("diamond_stone", "score", expected_score, int'(score));
        park_home("diamond_stone");
        // Object 0 already taken, hook keeps going
        launch_hook(110, 330, "diamond_stone");
        hold_state(gold_miner_pkg::stretching, 6, "diamond_stone");
        move_hook(5, 330);
        wait_state(gold_miner_pkg::missing, "diamond_stone");
        park_home("diamond_stone");
        report_test("diamond_stone", errors_before);
    endtask

    task automatic miss_off_bottom();
        int errors_before;
        int rx;
        int ry;
        errors_before = error_count;
        take_bits(10, rx);
        take_bits(5, ry);
        launch_hook(20 + rx, 250 + ry, "missing");
        hold_state(gold_miner_pkg::stretching, 4, "missing");
        move_hook(20 + rx, 760);
        wait_state(gold_miner_pkg::missing, "missing");
        check_value("missing", "score", expected_score, int'(score));
        park_home("missing");
        report_test("missing", errors_before);
    endtask

    task automatic countdown_and_game_over();
        int errors_before;
        int cycles;
        errors_before = error_count;
        apply_reset();
        expected_score = 0;
        repeat (`GM_TICKS_PER_SECOND) @(posedge pixclk_60);
        @(negedge pixclk_60);
        check_value("game_over", "time_left", `GM_ROUND_SECONDS - 1, int'(time_left));
        fire_and_reach(410, 460, gold_miner_pkg::hitting, "game_over");
        expected_score += `GM_GOLD_POINTS;
        park_home("game_over");
        cycles = 0;
        while (!game_over && cycles < 5500)
        begin
            @(negedge pixclk_60);
            cycles++;
        end
        if (!game_over)
        begin
            $display("game_over: game_over did not rise within 5500 cycles");
            error_count++;
        end
        check_value("game_over", "time_left", 0, int'(time_left));
        // Button and a catchable spot must both be ignored now
        move_hook(810, 360);
        press_button();
        hold_state(gold_miner_pkg::waving, 10, "game_over");
        report_test("game_over", errors_before);
    endtask

    initial
    begin
        pixclk_60 = 1'b0;
        rst = 1'b1;
        button = 1'b0;
        hook_pos.x = 600;
        hook_pos.y = 150;
        lfsr_state = 16'd36054;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        expected_score = 0;
        apply_reset();
        reset_values();
        gold_catch_and_return();
        diamond_stone_and_recatch();
        miss_off_bottom();
        countdown_and_game_over();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* gold_miner.f */
+incdir+hdl
hdl/gold_miner_pkg.sv
hdl/catch_detector.sv
hdl/round_timer.sv
hdl/hook_controller.sv
hdl/gold_miner_core.sv
verif/gold_miner_tb.sv

/* Bender.yml */
package:
  name: gold_miner

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gold_miner_pkg.sv
      - hdl/catch_detector.sv
      - hdl/round_timer.sv
      - hdl/hook_controller.sv
      - hdl/gold_miner_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/gold_miner_tb.sv
